// File: vlog.f
mem_adapter_pkg.sv
req_arbiter.sv
req_fifo.sv
wb_master.sv
mem_adapter_top.sv
mem_adapter_checker.sv
tb_mem_adapter.sv

// File: Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert -Wno-fatal
TOP      := tb_mem_adapter
FILELIST := vlog.f
LOG      := sim.log
BIN      := obj_dir/V$(TOP)
SRCS     := $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Testbench failed" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@if ! grep -q "Testbench passed" $(LOG); then echo "Simulation did not complete"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

// File: tb_mem_adapter.sv
`timescale 1ns/1ps

module tb_mem_adapter;

  localparam int N_REQ      = 60;
  localparam int MAX_CYCLES = 200 * N_REQ;

  logic                                clk;
  logic                                rst_n;
  logic [2:0]                          req_valid;
  logic [2:0]                          req_ready;
  mem_adapter_pkg::icache_miss_t       icache_miss;
  mem_adapter_pkg::mem_req_t           dread_req;
  mem_adapter_pkg::mem_req_t           ucwrite_req;
  logic                                wb_cyc;
  logic                                wb_stb;
  logic                                wb_we;
  logic [mem_adapter_pkg::ADDR_W-1:0]  wb_adr;
  logic [mem_adapter_pkg::DATA_W-1:0]  wb_wdata;
  logic [mem_adapter_pkg::SEL_W-1:0]   wb_sel;
  logic [mem_adapter_pkg::DATA_W-1:0]  wb_rdata;
  logic                                wb_ack;
  logic [mem_adapter_pkg::N_PORTS-1:0] resp_valid;
  logic [mem_adapter_pkg::N_PORTS-1:0] resp_ready;
  mem_adapter_pkg::mem_resp_t          resp [mem_adapter_pkg::N_PORTS];

  // Slave memory and the reference copy updated at request acceptance
  logic [63:0]                mem [256];
  logic [63:0]                ref_mem [256];
  mem_adapter_pkg::mem_resp_t exp_q [mem_adapter_pkg::N_PORTS][$];
  logic [31:0]                lcg_state = 32'd56;
  int                         err_data;
  int                         err_id;
  int                         err_last;
  int                         err_grant;
  int                         err_other;
  int                         cycles = 0;
  // Last granted port, -1 until the first grant
  int                         last_grant = -1;

  mem_adapter_top u_mem_adapter_top (
    .clk_i           (clk),
    .rst_n_i         (rst_n),
    .icache_valid_i  (req_valid[0]),
    .icache_miss_i   (icache_miss),
    .icache_ready_o  (req_ready[0]),
    .dread_valid_i   (req_valid[1]),
    .dread_req_i     (dread_req),
    .dread_ready_o   (req_ready[1]),
    .ucwrite_valid_i (req_valid[2]),
    .ucwrite_req_i   (ucwrite_req),
    .ucwrite_ready_o (req_ready[2]),
    .wb_cyc_o        (wb_cyc),
    .wb_stb_o        (wb_stb),
    .wb_we_o         (wb_we),
    .wb_adr_o        (wb_adr),
    .wb_dat_o        (wb_wdata),
    .wb_sel_o        (wb_sel),
    .wb_dat_i        (wb_rdata),
    .wb_ack_i        (wb_ack),
    .resp_valid_o    (resp_valid),
    .resp_o          (resp),
    .resp_ready_i    (resp_ready)
  );

  bind mem_adapter_top mem_adapter_checker u_mem_adapter_checker (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .cyc_i        (wb_cyc_o),
    .stb_i        (wb_stb_o),
    .ack_i        (wb_ack_i),
    .adr_i        (wb_adr_o),
    .resp_valid_i (resp_valid_o),
    .resp_ready_i (resp_ready_i)
  );

  // Halves swapped so the weak low bits of the LCG sit on top
  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return {lcg_state[15:0], lcg_state[31:16]};
  endfunction

  function automatic logic [63:0] merge_bytes(input logic [63:0] old, input logic [63:0] wdata,
                                              input logic [7:0] sel);
    logic [63:0] res;
    res = old;
    for (int b = 0; b < 8; b++) begin
      if (sel[b]) begin
        res[8*b +: 8] = wdata[8*b +: 8];
      end
    end
    return res;
  endfunction

  // First valid port after the last granted one
  function automatic int next_grant(input int last, input logic [2:0] valid);
    int pick;
    pick = last;
    for (int k = 3; k >= 1; k--) begin
      if (valid[(last + k) % 3]) begin
        pick = (last + k) % 3;
      end
    end
    return pick;
  endfunction

  task automatic expect_beats(input int p, input logic [31:0] base, input int beats,
                              input logic [3:0] id);
    mem_adapter_pkg::mem_resp_t e;
    for (int k = 0; k < beats; k++) begin
      e.data = ref_mem[8'(int'(base[10:3]) + k)];
      e.id   = id;
      e.last = (k == beats - 1);
      exp_q[p].push_back(e);
    end
  endtask

  task automatic check_beat(input int p);
    mem_adapter_pkg::mem_resp_t e;
    if (exp_q[p].size() == 0) begin
      err_other++;
      $display("Port %0d returned a response beat that no request was waiting for", p);
    end else begin
      e = exp_q[p].pop_front();
      // Write responses carry no data worth checking
      if (p != 2 && resp[p].data !== e.data) begin
        err_data++;
        $display("** Error: resp_o[%0d].data = %h, expected %h", p, resp[p].data, e.data);
      end
      if (resp[p].id !== e.id) begin
        err_id++;
        $display("** Error: resp_o[%0d].id = %h, expected %h", p, resp[p].id, e.id);
      end
      if (resp[p].last !== e.last) begin
        err_last++;
        $display("** Error: resp_o[%0d].last = %h, expected %h", p, resp[p].last, e.last);
      end
    end
  endtask

  task automatic print_counts();
    $display("Errors: data %0d, id %0d, last %0d, grant %0d, other %0d",
             err_data, err_id, err_last, err_grant, err_other);
  endtask

  // One requester issuing N_REQ/3 random requests
  task automatic run_port(input int p);
    logic [31:0] r;
    int          gap;
    @(posedge clk);
    for (int n = 0; n < N_REQ / 3; n++) begin
      #1;
      r = lcg_next();
      case (p)
        0: begin
          icache_miss.paddr = r & 32'h0000_07FF;
          icache_miss.nc    = (lcg_next() % 3) == 0;
          icache_miss.id    = 4'(lcg_next());
        end
        1: begin
          dread_req           = '0;
          dread_req.addr      = r & 32'h0000_00F8;
          dread_req.len       = 3'(lcg_next() % 4);
          dread_req.sel       = '1;
          dread_req.id        = 4'(lcg_next());
          dread_req.cacheable = 1'b1;
        end
        default: begin
          ucwrite_req       = '0;
          ucwrite_req.addr  = r & 32'h0000_00F8;
          ucwrite_req.we    = 1'b1;
          ucwrite_req.wdata = {lcg_next(), lcg_next()};
          ucwrite_req.sel   = 8'(lcg_next());
          ucwrite_req.id    = 4'(lcg_next());
        end
      endcase
      req_valid[p] = 1'b1;
      @(posedge clk);
      while (!req_ready[p]) begin
        @(posedge clk);
      end
      gap = int'(lcg_next() % 4);
      if (gap != 0) begin
        #1;
        req_valid[p] = 1'b0;
        repeat (gap) @(posedge clk);
      end
    end
    #1;
    req_valid[p] = 1'b0;
  endtask

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Wishbone slave with 0 to 3 wait states per beat
  initial begin
    int waits;
    int idx;
    forever begin
      @(posedge clk);
      if (rst_n && wb_cyc && wb_stb) begin
        waits = int'(lcg_next() % 4);
        repeat (waits) @(posedge clk);
        #1;
        idx = int'(wb_adr[10:3]);
        if (wb_we) begin
          mem[idx] = merge_bytes(mem[idx], wb_wdata, wb_sel);
        end else begin
          wb_rdata = mem[idx];
        end
        wb_ack = 1'b1;
        @(posedge clk);
        #1;
        wb_ack = 1'b0;
      end
    end
  end

  always @(posedge clk) begin
    #1;
    resp_ready = 3'(lcg_next()) | 3'(lcg_next());
  end

  // Reference model and response checks
  always @(posedge clk) begin
    mem_adapter_pkg::mem_resp_t e;
    int                         grant;
    if (rst_n) begin
      if (req_valid[0] && req_ready[0]) begin
        if (icache_miss.nc) begin
          expect_beats(0, {icache_miss.paddr[31:3], 3'b0}, 1, icache_miss.id);
        end else begin
          expect_beats(0, {icache_miss.paddr[31:5], 5'b0}, 4, icache_miss.id);
        end
      end
      if (req_valid[1] && req_ready[1]) begin
        expect_beats(1, dread_req.addr, int'(dread_req.len) + 1, dread_req.id);
      end
      if (req_valid[2] && req_ready[2]) begin
        ref_mem[ucwrite_req.addr[10:3]] = merge_bytes(ref_mem[ucwrite_req.addr[10:3]],
                                                      ucwrite_req.wdata, ucwrite_req.sel);
        e.data = '0;
        e.id   = ucwrite_req.id;
        e.last = 1'b1;
        exp_q[2].push_back(e);
      end
      // One-hot ready on a valid port, round-robin after the first grant
      if (req_ready != '0) begin
        if (last_grant < 0) begin
          grant = $clog2(req_ready);
        end else begin
          grant = next_grant(last_grant, req_valid);
        end
        if (req_ready !== 3'(1 << grant) || !req_valid[grant]) begin
          err_grant++;
          $display("** Error: {ucwrite,dread,icache}_ready_o = %h, expected %h",
                   req_ready, 3'(1 << grant));
        end
        last_grant = grant;
      end
      for (int p = 0; p < mem_adapter_pkg::N_PORTS; p++) begin
        if (resp_valid[p] && resp_ready[p]) begin
          check_beat(p);
        end
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > MAX_CYCLES) begin
      $display("Timeout: responses still outstanding after %0d cycles", MAX_CYCLES);
      print_counts();
      $display("Testbench failed");
      $finish;
    end
  end

  initial begin
    rst_n       = 1'b0;
    req_valid   = '0;
    icache_miss = '0;
    dread_req   = '0;
    ucwrite_req = '0;
    wb_rdata    = '0;
    wb_ack      = 1'b0;
    resp_ready  = '0;
    err_data    = 0;
    err_id      = 0;
    err_last    = 0;
    err_grant   = 0;
    err_other   = 0;
    for (int i = 0; i < 256; i++) begin
      mem[i]     = {32'(i) * 32'h9E37_79B9, 32'h0BAD_0000 | 32'(i)};
      ref_mem[i] = mem[i];
    end
    repeat (10) @(posedge clk);
    #1;
    rst_n = 1'b1;
    // Bus, ready and response side quiet before any request
    repeat (3) begin
      @(posedge clk);
      if (wb_cyc || wb_stb || req_ready != '0 || resp_valid != '0) begin
        err_other++;
        $display("Bus cycle, ready or response valid active after reset with no request");
      end
    end
    fork
      run_port(0);
      run_port(1);
      run_port(2);
    join
    while (exp_q[0].size() + exp_q[1].size() + exp_q[2].size() != 0) begin
      @(posedge clk);
    end
    repeat (4) @(posedge clk);
    print_counts();
    if (err_data + err_id + err_last + err_grant + err_other == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

// File: mem_adapter_checker.sv
`timescale 1ns/1ps

module mem_adapter_checker (
  input logic                                clk_i,
  input logic                                rst_n_i,
  input logic                                cyc_i,
  input logic                                stb_i,
  input logic                                ack_i,
  input logic [mem_adapter_pkg::ADDR_W-1:0]  adr_i,
  input logic [mem_adapter_pkg::N_PORTS-1:0] resp_valid_i,
  input logic [mem_adapter_pkg::N_PORTS-1:0] resp_ready_i
);

  // Strobe only inside a cycle, and held with it until the slave acks
  stb_in_cyc: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (stb_i || $past(stb_i && !ack_i)) |-> (stb_i && cyc_i))
    else $error("wb_stb_o outside wb_cyc_o or dropped before wb_ack_i");

  // Address held until the slave acks the beat
  adr_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (stb_i && !ack_i) |=> $stable(adr_i))
    else $error("wb_adr_o changed during a beat that was not acked");

  for (genvar p = 0; p < mem_adapter_pkg::N_PORTS; p++) begin : g_resp
    resp_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (resp_valid_i[p] && !resp_ready_i[p]) |=> resp_valid_i[p])
      else $error("resp_valid_o[%0d] dropped before resp_ready_i", p);
  end

endmodule

// File: mem_adapter_top.sv
`timescale 1ns/1ps

module mem_adapter_top (
  input  logic                                clk_i,
  input  logic                                rst_n_i,

  // Cache side requests
  input  logic                                icache_valid_i,
  input  mem_adapter_pkg::icache_miss_t       icache_miss_i,
  output logic                                icache_ready_o,
  input  logic                                dread_valid_i,
  input  mem_adapter_pkg::mem_req_t           dread_req_i,
  output logic                                dread_ready_o,
  input  logic                                ucwrite_valid_i,
  input  mem_adapter_pkg::mem_req_t           ucwrite_req_i,
  output logic                                ucwrite_ready_o,

  // Wishbone master
  output logic                                wb_cyc_o,
  output logic                                wb_stb_o,
  output logic                                wb_we_o,
  output logic [mem_adapter_pkg::ADDR_W-1:0]  wb_adr_o,
  output logic [mem_adapter_pkg::DATA_W-1:0]  wb_dat_o,
  output logic [mem_adapter_pkg::SEL_W-1:0]   wb_sel_o,
  input  logic [mem_adapter_pkg::DATA_W-1:0]  wb_dat_i,
  input  logic                                wb_ack_i,

  // Cache side responses
  output logic [mem_adapter_pkg::N_PORTS-1:0] resp_valid_o,
  output mem_adapter_pkg::mem_resp_t          resp_o [mem_adapter_pkg::N_PORTS],
  input  logic [mem_adapter_pkg::N_PORTS-1:0] resp_ready_i
);

  logic                        push;
  logic                        not_full;
  logic                        pop;
  logic                        not_empty;
  mem_adapter_pkg::buf_entry_t push_entry;
  mem_adapter_pkg::buf_entry_t head;

  req_arbiter u_req_arbiter (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .icache_valid_i  (icache_valid_i),
    .icache_miss_i   (icache_miss_i),
    .icache_ready_o  (icache_ready_o),
    .dread_valid_i   (dread_valid_i),
    .dread_req_i     (dread_req_i),
    .dread_ready_o   (dread_ready_o),
    .ucwrite_valid_i (ucwrite_valid_i),
    .ucwrite_req_i   (ucwrite_req_i),
    .ucwrite_ready_o (ucwrite_ready_o),
    .push_o          (push),
    .push_entry_o    (push_entry),
    .not_full_i      (not_full)
  );

  req_fifo u_req_fifo (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .push_i       (push),
    .push_entry_i (push_entry),
    .not_full_o   (not_full),
    .pop_i        (pop),
    .head_o       (head),
    .not_empty_o  (not_empty)
  );

  wb_master u_wb_master (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .not_empty_i  (not_empty),
    .head_i       (head),
    .pop_o        (pop),
    .wb_cyc_o     (wb_cyc_o),
    .wb_stb_o     (wb_stb_o),
    .wb_we_o      (wb_we_o),
    .wb_adr_o     (wb_adr_o),
    .wb_dat_o     (wb_dat_o),
    .wb_sel_o     (wb_sel_o),
    .wb_dat_i     (wb_dat_i),
    .wb_ack_i     (wb_ack_i),
    .resp_valid_o (resp_valid_o),
    .resp_o       (resp_o),
    .resp_ready_i (resp_ready_i)
  );

endmodule

// File: wb_master.sv
`timescale 1ns/1ps

module wb_master (
  input  logic                                clk_i,
  input  logic                                rst_n_i,

  input  logic                                not_empty_i,
  input  mem_adapter_pkg::buf_entry_t         head_i,
  output logic                                pop_o,

  output logic                                wb_cyc_o,
  output logic                                wb_stb_o,
  output logic                                wb_we_o,
  output logic [mem_adapter_pkg::ADDR_W-1:0]  wb_adr_o,
  output logic [mem_adapter_pkg::DATA_W-1:0]  wb_dat_o,
  output logic [mem_adapter_pkg::SEL_W-1:0]   wb_sel_o,
  input  logic [mem_adapter_pkg::DATA_W-1:0]  wb_dat_i,
  input  logic                                wb_ack_i,

  output logic [mem_adapter_pkg::N_PORTS-1:0] resp_valid_o,
  output mem_adapter_pkg::mem_resp_t          resp_o [mem_adapter_pkg::N_PORTS],
  input  logic [mem_adapter_pkg::N_PORTS-1:0] resp_ready_i
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_BUS,
    ST_RESP
  } state_e;

  state_e                              state_q;
  mem_adapter_pkg::mem_req_t           cur_q;
  mem_adapter_pkg::port_idx_t          port_q;
  logic [mem_adapter_pkg::LEN_W-1:0]   beats_left_q;
  logic [mem_adapter_pkg::ADDR_W-1:0]  addr_q;
  logic [mem_adapter_pkg::N_PORTS-1:0] resp_valid_q;
  mem_adapter_pkg::mem_resp_t          resp_q [mem_adapter_pkg::N_PORTS];
  logic                                last_beat;
  logic                                beat_done;
  logic                                resp_taken;

  // A write always ends after its only beat
  assign last_beat  = cur_q.we || (beats_left_q == '0);
  assign beat_done  = (state_q == ST_BUS) && wb_ack_i;
  assign resp_taken = (state_q == ST_RESP) && resp_ready_i[port_q];

  assign pop_o = (state_q == ST_IDLE) && not_empty_i;

  // Classic cycle, cyc and stb move together
  assign wb_cyc_o = (state_q == ST_BUS);
  assign wb_stb_o = (state_q == ST_BUS);
  assign wb_we_o  = cur_q.we;
  assign wb_adr_o = addr_q;
  assign wb_dat_o = cur_q.wdata;
  assign wb_sel_o = cur_q.sel;

  assign resp_valid_o = resp_valid_q;
  assign resp_o       = resp_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q      <= ST_IDLE;
      resp_valid_q <= '0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (not_empty_i) begin
            state_q <= ST_BUS;
          end
        end
        ST_BUS: begin
          if (wb_ack_i) begin
            state_q              <= ST_RESP;
            resp_valid_q[port_q] <= 1'b1;
          end
        end
        ST_RESP: begin
          // Bus stays idle until the owner takes the beat
          if (resp_ready_i[port_q]) begin
            resp_valid_q[port_q] <= 1'b0;
            state_q              <= last_beat ? ST_IDLE : ST_BUS;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // Current request and beat tracking
  always_ff @(posedge clk_i) begin
    if (pop_o) begin
      cur_q        <= head_i.req;
      port_q       <= head_i.port;
      addr_q       <= head_i.req.addr;
      beats_left_q <= head_i.req.len;
    end
    if (resp_taken && !last_beat) begin
      addr_q       <= addr_q + mem_adapter_pkg::ADDR_W'(mem_adapter_pkg::BEAT_BYTES);
      beats_left_q <= beats_left_q - 1'b1;
    end
  end

  // Response registers, one per port
  always_ff @(posedge clk_i) begin
    if (beat_done) begin
      resp_q[port_q].data <= cur_q.we ? '0 : wb_dat_i;
      resp_q[port_q].id   <= cur_q.id;
      resp_q[port_q].last <= last_beat;
    end
  end

endmodule

// File: req_fifo.sv
`timescale 1ns/1ps

module req_fifo (
  input  logic                        clk_i,
  input  logic                        rst_n_i,

  input  logic                        push_i,
  input  mem_adapter_pkg::buf_entry_t push_entry_i,
  output logic                        not_full_o,

  input  logic                        pop_i,
  output mem_adapter_pkg::buf_entry_t head_o,
  output logic                        not_empty_o
);

  localparam int DEPTH = 2;

  mem_adapter_pkg::buf_entry_t mem_q [DEPTH];
  logic                        wr_ptr_q;
  logic                        rd_ptr_q;
  logic [1:0]                  count_q;
  logic                        do_push;
  logic                        do_pop;

  assign not_full_o  = (count_q != 2'(DEPTH));
  assign not_empty_o = (count_q != 2'd0);
  assign head_o      = mem_q[rd_ptr_q];

  assign do_push = push_i && not_full_o;
  assign do_pop  = pop_i && not_empty_o;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
      count_q  <= 2'd0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= ~wr_ptr_q;
      end
      if (do_pop) begin
        rd_ptr_q <= ~rd_ptr_q;
      end
      // Simultaneous push and pop keeps the count
      if (do_push && !do_pop) begin
        count_q <= count_q + 2'd1;
      end else if (do_pop && !do_push) begin
        count_q <= count_q - 2'd1;
      end
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= push_entry_i;
    end
  end

endmodule

// File: req_arbiter.sv
`timescale 1ns/1ps

module req_arbiter (
  input  logic                         clk_i,
  input  logic                         rst_n_i,

  input  logic                         icache_valid_i,
  input  mem_adapter_pkg::icache_miss_t icache_miss_i,
  output logic                         icache_ready_o,

  input  logic                         dread_valid_i,
  input  mem_adapter_pkg::mem_req_t    dread_req_i,
  output logic                         dread_ready_o,

  input  logic                         ucwrite_valid_i,
  input  mem_adapter_pkg::mem_req_t    ucwrite_req_i,
  output logic                         ucwrite_ready_o,

  output logic                         push_o,
  output mem_adapter_pkg::buf_entry_t  push_entry_o,
  input  logic                         not_full_i
);

  mem_adapter_pkg::mem_req_t           req_vec [mem_adapter_pkg::N_PORTS];
  logic [mem_adapter_pkg::N_PORTS-1:0] valid_vec;
  mem_adapter_pkg::port_idx_t          last_q;
  mem_adapter_pkg::port_idx_t          grant_idx;
  mem_adapter_pkg::port_idx_t          cand;
  logic                                grant_found;

  // Instruction miss becomes a read
  always_comb begin
    req_vec[mem_adapter_pkg::PORT_ICACHE]           = '0;
    req_vec[mem_adapter_pkg::PORT_ICACHE].id        = icache_miss_i.id;
    req_vec[mem_adapter_pkg::PORT_ICACHE].sel       = '1;
    req_vec[mem_adapter_pkg::PORT_ICACHE].cacheable = ~icache_miss_i.nc;
    if (icache_miss_i.nc) begin
      // Single word, aligned to the beat
      req_vec[mem_adapter_pkg::PORT_ICACHE].len  = '0;
      req_vec[mem_adapter_pkg::PORT_ICACHE].addr =
        {icache_miss_i.paddr[mem_adapter_pkg::ADDR_W-1:mem_adapter_pkg::BEAT_OFF_W],
         {mem_adapter_pkg::BEAT_OFF_W{1'b0}}};
    end else begin
      // Whole line from its first byte
      req_vec[mem_adapter_pkg::PORT_ICACHE].len  =
        mem_adapter_pkg::LEN_W'(mem_adapter_pkg::LINE_BEATS - 1);
      req_vec[mem_adapter_pkg::PORT_ICACHE].addr =
        {icache_miss_i.paddr[mem_adapter_pkg::ADDR_W-1:mem_adapter_pkg::LINE_OFF_W],
         {mem_adapter_pkg::LINE_OFF_W{1'b0}}};
    end
  end

  // Port position fixes the direction
  always_comb begin
    req_vec[mem_adapter_pkg::PORT_DREAD]        = dread_req_i;
    req_vec[mem_adapter_pkg::PORT_DREAD].we     = 1'b0;
    req_vec[mem_adapter_pkg::PORT_UCWRITE]      = ucwrite_req_i;
    req_vec[mem_adapter_pkg::PORT_UCWRITE].we   = 1'b1;
    req_vec[mem_adapter_pkg::PORT_UCWRITE].len  = '0;
  end

  assign valid_vec = {ucwrite_valid_i, dread_valid_i, icache_valid_i};

  // First valid port after the last grant
  always_comb begin
    grant_idx   = last_q;
    grant_found = 1'b0;
    cand        = '0;
    for (int k = 1; k <= mem_adapter_pkg::N_PORTS; k++) begin
      cand = mem_adapter_pkg::port_idx_t'((int'(last_q) + k) % mem_adapter_pkg::N_PORTS);
      if (!grant_found && valid_vec[cand]) begin
        grant_idx   = cand;
        grant_found = 1'b1;
      end
    end
  end

  assign push_o            = grant_found && not_full_i;
  assign push_entry_o.req  = req_vec[grant_idx];
  assign push_entry_o.port = grant_idx;

  assign icache_ready_o  = push_o && (grant_idx == mem_adapter_pkg::PORT_ICACHE);
  assign dread_ready_o   = push_o && (grant_idx == mem_adapter_pkg::PORT_DREAD);
  assign ucwrite_ready_o = push_o && (grant_idx == mem_adapter_pkg::PORT_UCWRITE);

  // Start so that the instruction port wins first
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      last_q <= mem_adapter_pkg::PORT_UCWRITE;
    end else if (push_o) begin
      last_q <= grant_idx;
    end
  end

endmodule

// File: mem_adapter_pkg.sv
package mem_adapter_pkg;

  // Bus and request widths
  localparam int ADDR_W     = 32;
  localparam int DATA_W     = 64;
  localparam int SEL_W      = DATA_W / 8;
  localparam int ID_W       = 4;
  localparam int LEN_W      = 3;
  localparam int LINE_BEATS = 4;
  localparam int N_PORTS    = 3;

  // Byte geometry of a beat and of an instruction line
  localparam int BEAT_BYTES = DATA_W / 8;
  localparam int BEAT_OFF_W = $clog2(BEAT_BYTES);
  localparam int LINE_OFF_W = $clog2(LINE_BEATS * BEAT_BYTES);

  typedef logic [1:0] port_idx_t;

  // Fixed requester positions
  localparam port_idx_t PORT_ICACHE  = 2'd0;
  localparam port_idx_t PORT_DREAD   = 2'd1;
  localparam port_idx_t PORT_UCWRITE = 2'd2;

  typedef struct packed {
    logic [ADDR_W-1:0] paddr;
    logic              nc;
    logic [ID_W-1:0]   id;
  } icache_miss_t;

  // len holds the beat count minus one
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [LEN_W-1:0]  len;
    logic              we;
    logic [DATA_W-1:0] wdata;
    logic [SEL_W-1:0]  sel;
    logic [ID_W-1:0]   id;
    logic              cacheable;
  } mem_req_t;

  typedef struct packed {
    mem_req_t  req;
    port_idx_t port;
  } buf_entry_t;

  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic [ID_W-1:0]   id;
    logic              last;
  } mem_resp_t;

endpackage
